// ==== axis_pkg.sv ====
`default_nettype none

package axis_pkg;

    // stream widths
    localparam int data_width = 32;
    localparam int keep_width = data_width / 8;
    localparam int user_width = 1;

    // beat payload, also used for the frame checksum
    typedef logic [data_width-1:0] axis_data_t;

    // one bit per byte lane
    typedef logic [keep_width-1:0] axis_keep_t;

    // side flag carried along with each beat
    typedef logic [user_width-1:0] axis_user_t;

    // one stream beat, 38 bits wide
    typedef struct packed
    {
        axis_data_t data;
        axis_keep_t keep;
        axis_user_t user;
        logic       last;
    } axis_beat_t;

    // checksum stage state
    // st_data: passing frame beats through
    // st_sum: final data beat is held in the output register,
    // the sum beat follows once it leaves
    typedef enum logic [0:0]
    {
        st_data = 1'b0,
        st_sum  = 1'b1
    } sum_state_t;

endpackage

`default_nettype wire

// ==== axis_reg_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_reg_slice #(
    parameter bit forward_registered = 1'b1,
    parameter bit back_registered    = 1'b1
)(
    input  wire                  clk,
    input  wire                  rst_n,

    // upstream side
    input  axis_pkg::axis_beat_t s_beat,
    input  wire                  s_valid,
    output logic                 s_ready,

    // downstream side
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  wire                  m_ready
);

    // link between the backward and the forward stage
    axis_pkg::axis_beat_t mid_beat;
    logic                 mid_valid;
    logic                 mid_ready;

    // backward stage, the skid buffer on the upstream side
    generate
        if (back_registered)
        begin : g_back
            axis_pkg::axis_beat_t skid_beat;
            logic                 skid_valid;

            // ready comes straight from a flop, so the upstream ready path is cut
            assign s_ready = ~skid_valid;

            // a held beat always goes out before a new one
            assign mid_valid = s_valid | skid_valid;
            assign mid_beat  = skid_valid ? skid_beat : s_beat;

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    skid_valid <= 1'b0;
                end
                else if (skid_valid && mid_ready)
                begin
                    skid_valid <= 1'b0;
                end
                else if (s_valid && s_ready && !mid_ready)
                begin
                    // downstream stalled while this beat was in flight
                    skid_valid <= 1'b1;
                end
            end

            always_ff @(posedge clk)
            begin
                if (s_valid && s_ready && !mid_ready)
                begin
                    skid_beat <= s_beat;
                end
            end
        end
        else
        begin : g_no_back
            assign s_ready   = mid_ready;
            assign mid_valid = s_valid;
            assign mid_beat  = s_beat;
        end
    endgenerate

    // forward stage, the output register on the downstream side
    generate
        if (forward_registered)
        begin : g_fwd
            axis_pkg::axis_beat_t out_beat;
            logic                 out_valid;

            // take a new beat when empty or when the held one leaves
            assign mid_ready = ~out_valid | m_ready;
            assign m_valid   = out_valid;
            assign m_beat    = out_beat;

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    out_valid <= 1'b0;
                end
                else if (mid_valid && mid_ready)
                begin
                    out_valid <= 1'b1;
                end
                else if (m_ready)
                begin
                    out_valid <= 1'b0;
                end
            end

            always_ff @(posedge clk)
            begin
                if (mid_valid && mid_ready)
                begin
                    out_beat <= mid_beat;
                end
            end
        end
        else
        begin : g_no_fwd
            assign mid_ready = m_ready;
            assign m_valid   = mid_valid;
            assign m_beat    = mid_beat;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== axis_frame_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_frame_sum (
    input  wire                  clk,
    input  wire                  rst_n,

    // frame input
    input  axis_pkg::axis_beat_t s_beat,
    input  wire                  s_valid,
    output logic                 s_ready,

    // frame output with the sum beat appended
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  wire                  m_ready
);

    axis_pkg::sum_state_t state;

    // running checksum and user flag of the current frame
    axis_pkg::axis_data_t sum_acc;
    axis_pkg::axis_user_t user_or;

    // byte sum of the incoming beat
    axis_pkg::axis_data_t beat_sum;

    // candidate values for the output register
    axis_pkg::axis_beat_t fwd_beat;
    axis_pkg::axis_beat_t sum_beat;

    // one-deep output register
    axis_pkg::axis_beat_t out_beat;
    logic                 out_valid;

    logic in_fire;
    logic out_fire;

    // no input while the final data beat waits, its slot goes to the sum beat
    assign s_ready  = (state == axis_pkg::st_data) && (!out_valid || m_ready);
    assign in_fire  = s_valid && s_ready;
    assign out_fire = out_valid && m_ready;

    assign m_beat  = out_beat;
    assign m_valid = out_valid;

    // add up the bytes with their keep bit set, sparse patterns included
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < axis_pkg::keep_width; i++)
        begin
            if (s_beat.keep[i])
            begin
                beat_sum = beat_sum + axis_pkg::axis_data_t'(s_beat.data[8*i +: 8]);
            end
        end
    end

    // data beats go out untouched apart from last,
    // which now belongs to the sum beat
    always_comb
    begin
        fwd_beat      = s_beat;
        fwd_beat.last = 1'b0;
    end

    always_comb
    begin
        sum_beat.data = sum_acc;
        sum_beat.keep = '1;
        sum_beat.user = user_or;
        sum_beat.last = 1'b1;
    end

    // state, valid and accumulators
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= axis_pkg::st_data;
            out_valid <= 1'b0;
            sum_acc   <= '0;
            user_or   <= '0;
        end
        else
        begin
            case (state)
                axis_pkg::st_data:
                begin
                    if (in_fire)
                    begin
                        out_valid <= 1'b1;
                        sum_acc   <= sum_acc + beat_sum;
                        user_or   <= user_or | s_beat.user;
                        if (s_beat.last)
                        begin
                            state <= axis_pkg::st_sum;
                        end
                    end
                    else if (out_fire)
                    begin
                        out_valid <= 1'b0;
                    end
                end

                axis_pkg::st_sum:
                begin
                    // final data beat leaves, sum beat takes its place
                    if (out_fire)
                    begin
                        state   <= axis_pkg::st_data;
                        sum_acc <= '0;
                        user_or <= '0;
                    end
                end

                default:
                begin
                    state <= axis_pkg::st_data;
                end
            endcase
        end
    end

    // output payload
    always_ff @(posedge clk)
    begin
        if (state == axis_pkg::st_data)
        begin
            if (in_fire)
            begin
                out_beat <= fwd_beat;
            end
        end
        else if (out_fire)
        begin
            out_beat <= sum_beat;
        end
    end

endmodule

`default_nettype wire

// ==== axis_sum_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axis_sum_top (
    input  wire                  clk,
    input  wire                  rst_n,

    // frames in
    input  axis_pkg::axis_beat_t s_beat,
    input  wire                  s_valid,
    output logic                 s_ready,

    // frames out, each followed by its checksum beat
    output axis_pkg::axis_beat_t m_beat,
    output logic                 m_valid,
    input  wire                  m_ready
);

    // input slice to checksum stage
    axis_pkg::axis_beat_t in_beat;
    logic                 in_valid;
    logic                 in_ready;

    // checksum stage to output slice
    axis_pkg::axis_beat_t sum_beat;
    logic                 sum_valid;
    logic                 sum_ready;

    axis_reg_slice #(
        .forward_registered(1'b1),
        .back_registered   (1'b1)
    ) u_in_slice (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_beat (s_beat),
        .s_valid(s_valid),
        .s_ready(s_ready),
        .m_beat (in_beat),
        .m_valid(in_valid),
        .m_ready(in_ready)
    );

    axis_frame_sum u_frame_sum (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_beat (in_beat),
        .s_valid(in_valid),
        .s_ready(in_ready),
        .m_beat (sum_beat),
        .m_valid(sum_valid),
        .m_ready(sum_ready)
    );

    // registered ready here also cuts the m_ready path into the checksum stage
    axis_reg_slice #(
        .forward_registered(1'b1),
        .back_registered   (1'b1)
    ) u_out_slice (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_beat (sum_beat),
        .s_valid(sum_valid),
        .s_ready(sum_ready),
        .m_beat (m_beat),
        .m_valid(m_valid),
        .m_ready(m_ready)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 5
)(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release lands just after an edge, like the rest of the stimulus
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_axis_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axis_sum;

    localparam int num_frames = 48;
    localparam int max_len    = 8;
    localparam int first_rand = 6;

    logic                 clk;
    logic                 rst_n;
    axis_pkg::axis_beat_t s_beat;
    logic                 s_valid;
    logic                 s_ready;
    axis_pkg::axis_beat_t m_beat;
    logic                 m_valid;
    logic                 m_ready;

    // expected output beats and the accept cycle of each timed beat
    axis_pkg::axis_beat_t exp_q[$];
    int                   lat_q[$];

    axis_pkg::axis_beat_t frame_buf[max_len];
    int                   frame_len[num_frames];

    logic [31:0] drv_rng = 32'hddffc2d7;
    logic [31:0] rdy_rng = 32'hddffc2d7 ^ 32'h5a5a5a5a;
    bit          bp_enable = 1'b0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    int          check_count = 0;

    tb_clk_gen #(
        .period_ns   (20),
        .reset_cycles(5)
    ) u_clk_gen (
        .clk  (clk),
        .rst_n(rst_n)
    );

    axis_sum_top i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .s_beat (s_beat),
        .s_valid(s_valid),
        .s_ready(s_ready),
        .m_beat (m_beat),
        .m_valid(m_valid),
        .m_ready(m_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_random();
        drv_rng = xorshift32(drv_rng);
        return drv_rng;
    endfunction

    // closing beat holds the sum of the kept bytes mod 2^32 and the OR of the user flags
    function automatic axis_pkg::axis_beat_t frame_sum_ref(
        input axis_pkg::axis_beat_t beats[max_len],
        input int                   len
    );
        axis_pkg::axis_beat_t res;
        logic [31:0]          total;
        logic                 user_any;
        total    = '0;
        user_any = 1'b0;
        for (int b = 0; b < len; b++)
        begin
            user_any = user_any | beats[b].user[0];
            for (int k = 0; k < axis_pkg::keep_width; k++)
            begin
                if (beats[b].keep[k])
                begin
                    total = total + {24'd0, beats[b].data[8*k +: 8]};
                end
            end
        end
        res.data = total;
        res.keep = '1;
        res.user = user_any;
        res.last = 1'b1;
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        check_count++;
        assert (act_v === exp_v)
        else
        begin
            error_count++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    endtask

    // starts 2 ns after an edge and returns 2 ns after the edge that takes the last beat
    task automatic send_frame(input int len, input bit gaps, input bit timed, input bit sparse);
        logic [31:0]          r;
        int                   idle;
        axis_pkg::axis_beat_t exp;
        for (int i = 0; i < len; i++)
        begin
            r                 = draw_random();
            frame_buf[i].data = draw_random();
            frame_buf[i].keep = (r[3:0] == 4'd0) ? 4'b0001 : r[3:0];
            if (sparse)
                frame_buf[i].keep = i[0] ? 4'b1010 : 4'b0101;
            frame_buf[i].user = r[4];
            frame_buf[i].last = (i == len - 1);
        end
        for (int i = 0; i < len; i++)
        begin
            if (gaps)
            begin
                idle = draw_random() % 4;
                if (idle > 0)
                begin
                    s_valid = 1'b0;
                    repeat (idle) @(posedge clk);
                    #2;
                end
            end
            s_beat  = frame_buf[i];
            s_valid = 1'b1;
            do
                @(posedge clk);
            while (!s_ready);
            exp      = frame_buf[i];
            exp.last = 1'b0;
            exp_q.push_back(exp);
            lat_q.push_back(timed ? cycle_cnt : -1);
            if (i == len - 1)
            begin
                exp_q.push_back(frame_sum_ref(frame_buf, len));
                lat_q.push_back(-1);
            end
            #2;
            s_valid = 1'b0;
        end
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // m_ready drops about one cycle in four once back-pressure is enabled
    initial
    begin
        m_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            #2;
            if (bp_enable)
            begin
                rdy_rng = xorshift32(rdy_rng);
                m_ready = (rdy_rng[1:0] != 2'd0);
            end
            else
            begin
                m_ready = 1'b1;
            end
        end
    end

    // compare every output transfer with the head of the expected queue
    always @(posedge clk)
    begin
        axis_pkg::axis_beat_t exp;
        int                   tag;
        if (rst_n && m_valid && m_ready)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                error_count++;
                $display("output beat at %0t arrived when no beat was expected", $time);
            end
            if (exp_q.size() != 0)
            begin
                exp = exp_q.pop_front();
                tag = lat_q.pop_front();
                check_value("m_beat.data", exp.data, m_beat.data);
                check_value("m_beat.keep", {28'd0, exp.keep}, {28'd0, m_beat.keep});
                check_value("m_beat.user", {31'd0, exp.user}, {31'd0, m_beat.user});
                check_value("m_beat.last", {31'd0, exp.last}, {31'd0, m_beat.last});
                if (tag >= 0)
                    check_value("latency", 32'd3, cycle_cnt - tag);
            end
        end
    end

    initial
    begin
        while (cycle_limit == 0 || cycle_cnt < cycle_limit)
            @(posedge clk);
        error_count++;
        $display("run timed out after %0d cycles with %0d beats still expected",
                 cycle_cnt, exp_q.size());
        finish_run();
    end

    initial
    begin
        int total_beats;
        int waited;
        s_beat  = '0;
        s_valid = 1'b0;

        // an isolated beat first, then continuous frames and then random traffic
        total_beats  = 0;
        frame_len[0] = 1;
        frame_len[1] = 1;
        frame_len[2] = 8;
        for (int f = 3; f < num_frames; f++)
            frame_len[f] = (draw_random() % max_len) + 1;
        for (int f = 0; f < num_frames; f++)
            total_beats += frame_len[f];
        cycle_limit = (total_beats + num_frames) * 8 + 200;

        @(posedge rst_n);
        @(posedge clk);
        check_value("m_valid", 32'd0, {31'd0, m_valid});
        waited = 0;
        while (!s_ready && waited < 4)
        begin
            @(posedge clk);
            waited++;
        end
        assert (s_ready)
        else
        begin
            error_count++;
            $display("s_ready did not come up within 4 cycles of reset release");
        end
        #2;

        send_frame(frame_len[0], 1'b0, 1'b1, 1'b0);
        while (exp_q.size() != 0)
            @(posedge clk);
        #2;

        // back to back frames with m_ready high, one-beat and sparse keep frames among them
        for (int f = 1; f < first_rand; f++)
            send_frame(frame_len[f], 1'b0, 1'b0, (f == 1) || (f == 3));

        bp_enable = 1'b1;
        for (int f = first_rand; f < num_frames; f++)
            send_frame(frame_len[f], 1'b1, 1'b0, 1'b0);

        waited = 0;
        while (exp_q.size() != 0 && waited < 300)
        begin
            @(posedge clk);
            waited++;
        end
        // extra cycles catch any duplicated beat
        repeat (20) @(posedge clk);
        assert (exp_q.size() == 0)
        else
        begin
            error_count++;
            $display("%0d expected beats never came out of the DUT", exp_q.size());
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== src.f ====
axis_pkg.sv
axis_reg_slice.sv
axis_frame_sum.sv
axis_sum_top.sv
tb_clk_gen.sv
tb_axis_sum.sv
